//--- logic/copper_beam_compare.sv
// Compares sampled on compare_i only; result is meaningful in the cycle after the strobe
`default_nettype none
`timescale 1ns/1ps

module copper_beam_compare (
    input  wire logic                     clk,
    input  wire logic                     copp_reset,
    input  wire logic                     compare_i,
    input  wire copper_pkg::copper_insn_u insn_i,
    input  wire copper_pkg::hres_t        h_count_i,
    input  wire copper_pkg::vres_t        v_count_i,
    output      logic                     cond_met_o
);

    logic v_reached;
    logic h_reached;

    // Registered compares, at or past the target
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            v_reached <= 1'b0;
            h_reached <= 1'b0;
        end else if (compare_i) begin
            v_reached <= (v_count_i >= insn_i.pos.v_target);
            h_reached <= (h_count_i >= insn_i.pos.h_target);
        end
    end

    // Ignore flags pick which compares count
    always_comb begin
        case ({insn_i.pos.ignore_v, insn_i.pos.ignore_h})
            // Both positions checked
            2'b00: cond_met_o = v_reached && h_reached;
            // Horizontal ignored
            2'b01: cond_met_o = v_reached;
            // Vertical ignored
            2'b10: cond_met_o = h_reached;
            // Nothing to check
            default: cond_met_o = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/copper_ctrl_reg.sv
// Control word is cleared by reset only; restart point assumes TOTAL_WIDTH >= 4 and fits hres_t
`default_nettype none
`timescale 1ns/1ps

module copper_ctrl_reg #(
    parameter int TOTAL_WIDTH  = 800,
    parameter int TOTAL_HEIGHT = 525
) (
    input  wire logic                   clk,
    input  wire logic                   copp_reset,
    input  wire logic                   copp_reg_wr_i,
    input  wire copper_pkg::copp_ctrl_t copp_reg_data_i,
    input  wire copper_pkg::hres_t      h_count_i,
    input  wire copper_pkg::vres_t      v_count_i,
    output      copper_pkg::copp_ctrl_t ctrl_o,
    output      logic                   frame_restart_o
);

    // Restart four pixels before the end of the last line
    // Leaves room for the five-cycle first fetch
    localparam copper_pkg::hres_t RESTART_H = copper_pkg::hres_t'(TOTAL_WIDTH - 4);
    localparam copper_pkg::vres_t RESTART_V = copper_pkg::vres_t'(TOTAL_HEIGHT - 1);

    copper_pkg::copp_ctrl_t ctrl_q;

    // Control word capture
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            ctrl_q <= '0;
        end else if (copp_reg_wr_i) begin
            ctrl_q <= copp_reg_data_i;
        end
    end

    assign ctrl_o = ctrl_q;

    // Single-cycle pulse, beam counters advance every clock
    assign frame_restart_o = (h_count_i == RESTART_H) && (v_count_i == RESTART_V);

endmodule

`default_nettype wire

//--- logic/copper_pkg.sv
// Shared copper types; PC width and beam widths fixed here, MOVEF/MOVEC/reserved opcodes are NOPs
package copper_pkg;

    // Copper program memory depth in 32-bit words
    localparam int COPP_W = 10;
    // Beam counter widths
    localparam int HRES_W = 11;
    localparam int VRES_W = 11;

    typedef logic [HRES_W-1:0] hres_t;
    typedef logic [VRES_W-1:0] vres_t;
    typedef logic [COPP_W-1:0] copp_pc_t;
    typedef logic [15:0]       word_t;
    typedef logic [15:0]       addr_t;

    // Color memory base, only bits [15:9] reach MOVEP addresses
    localparam addr_t XR_COLOR_MEM = 16'h8000;

    // Opcode field, top three bits of every instruction
    typedef enum logic [2:0] {
        OP_WAIT  = 3'b000,
        OP_SKIP  = 3'b001,
        OP_JMP   = 3'b010,
        OP_MOVER = 3'b011,
        OP_MOVEF = 3'b100,      // Decodes as NOP
        OP_MOVEP = 3'b101,
        OP_MOVEC = 3'b110,      // Decodes as NOP
        OP_RSVD  = 3'b111       // Decodes as NOP
    } opcode_e;

    // WAIT and SKIP view
    typedef struct packed {
        opcode_e     opcode;     // [31:29]
        logic [1:0]  rsvd_hi;    // [28:27]
        vres_t       v_target;   // [26:16]
        logic        rsvd_mid;   // [15]
        hres_t       h_target;   // [14:4]
        logic [1:0]  rsvd_flags; // [3:2]
        logic        ignore_h;   // [1]
        logic        ignore_v;   // [0]
    } insn_pos_t;

    // JMP view, target sits on a 32-bit boundary
    typedef struct packed {
        opcode_e     opcode;     // [31:29]
        logic [1:0]  rsvd_hi;    // [28:27]
        copp_pc_t    target_pc;  // [26:17]
        logic [16:0] rsvd_lo;    // [16:0]
    } insn_jmp_t;

    // MOVER and MOVEP view
    // MOVER uses index[7:0] as register number, MOVEP all nine bits as palette index
    typedef struct packed {
        opcode_e     opcode;     // [31:29]
        logic [3:0]  rsvd;       // [28:25]
        logic [8:0]  index;      // [24:16]
        word_t       data;       // [15:0]
    } insn_move_t;

    // One instruction word, decoded per opcode
    typedef union packed {
        insn_pos_t  pos;
        insn_jmp_t  jmp;
        insn_move_t move;
    } copper_insn_u;

    // Control register layout
    typedef struct packed {
        logic       enable;      // [15]
        logic [4:0] rsvd;        // [14:10]
        copp_pc_t   init_pc;     // [9:0]
    } copp_ctrl_t;

    // Write request, sequencer to writer
    typedef struct packed {
        logic  valid;
        addr_t addr;
        word_t data;
    } xr_wr_req_t;

endpackage

//--- logic/copper_sequencer.sv
// One instruction at a time; a MOVE stalls in EXEC while the previous write is unacknowledged
`default_nettype none
`timescale 1ns/1ps

module copper_sequencer (
    input  wire logic                     clk,
    input  wire logic                     copp_reset,
    input  wire copper_pkg::copp_ctrl_t   ctrl_i,
    input  wire logic                     frame_restart_i,
    input  wire logic [31:0]              coppermem_rd_data_i,
    input  wire logic                     cond_met_i,
    input  wire logic                     wr_busy_i,
    output      logic                     coppermem_rd_en_o,
    output      copper_pkg::copp_pc_t     coppermem_rd_addr_o,
    output      copper_pkg::copper_insn_u insn_o,
    output      logic                     compare_o,
    output      copper_pkg::xr_wr_req_t   wr_req_o
);

    // Execution states
    typedef enum logic [2:0] {
        ST_INIT    = 3'd0,
        ST_FETCH   = 3'd1,
        ST_LATCH   = 3'd2,
        ST_PRECOMP = 3'd3,
        ST_EXEC    = 3'd4
    } ex_state_e;

    ex_state_e                ex_state;
    copper_pkg::copp_pc_t     pc;
    logic                     rd_strobe;
    copper_pkg::copper_insn_u insn_q;

    // Decoded fields of the latched word
    copper_pkg::opcode_e      opcode;
    logic                     is_move;
    logic                     wait_forever;

    assign opcode       = insn_q.pos.opcode;
    assign is_move      = (opcode == copper_pkg::OP_MOVER) || (opcode == copper_pkg::OP_MOVEP);
    // Both compares ignored, WAIT parks until the next restart
    assign wait_forever = insn_q.pos.ignore_v && insn_q.pos.ignore_h;

    // Program memory port
    // Strobe is masked when the copper is switched off
    assign coppermem_rd_en_o   = rd_strobe && ctrl_i.enable;
    assign coppermem_rd_addr_o = pc;

    assign insn_o    = insn_q;
    // Beam compare samples during PRECOMP
    assign compare_o = (ex_state == ST_PRECOMP);

    // Write request, live only in EXEC of a MOVE
    always_comb begin
        wr_req_o.valid = (ex_state == ST_EXEC) && is_move && !wr_busy_i && !frame_restart_i;
        if (opcode == copper_pkg::OP_MOVEP) begin
            // Palette index under the color memory base
            wr_req_o.addr = {copper_pkg::XR_COLOR_MEM[15:9], insn_q.move.index};
        end else begin
            // Register number, upper byte zero
            wr_req_o.addr = {8'h00, insn_q.move.index[7:0]};
        end
        wr_req_o.data = insn_q.move.data;
    end

    // Instruction register
    // Memory data is valid in the cycle after the strobe
    always_ff @(posedge clk) begin
        if (ex_state == ST_LATCH) begin
            insn_q <= coppermem_rd_data_i;
        end
    end

    // Main state machine
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            ex_state  <= ST_INIT;
            pc        <= '0;
            rd_strobe <= 1'b0;
        end else begin
            // Strobe lasts one cycle unless reissued below
            rd_strobe <= 1'b0;

            if (frame_restart_i) begin
                // End of frame, restart from the programmed PC
                ex_state <= ST_INIT;
                pc       <= ctrl_i.init_pc;
            end else begin
                case (ex_state)
                    // First fetch after restart or while idle
                    ST_INIT: begin
                        if (ctrl_i.enable) begin
                            ex_state  <= ST_FETCH;
                            rd_strobe <= 1'b1;
                        end
                    end
                    // Read in flight, memory samples pc at this edge
                    ST_FETCH: begin
                        if (ctrl_i.enable) begin
                            ex_state <= ST_LATCH;
                            pc       <= pc + 1'b1;
                        end else begin
                            // Disabled, park in INIT
                            ex_state <= ST_INIT;
                        end
                    end
                    ST_LATCH: begin
                        ex_state <= ST_PRECOMP;
                    end
                    ST_PRECOMP: begin
                        ex_state <= ST_EXEC;
                    end
                    ST_EXEC: begin
                        case (opcode)
                            copper_pkg::OP_WAIT: begin
                                if (cond_met_i && !wait_forever) begin
                                    ex_state  <= ST_FETCH;
                                    rd_strobe <= 1'b1;
                                end else begin
                                    // Retry the compare, two cycles per pass
                                    ex_state <= ST_PRECOMP;
                                end
                            end
                            copper_pkg::OP_SKIP: begin
                                // pc already points past this insn
                                if (cond_met_i) begin
                                    pc <= pc + 1'b1;
                                end
                                ex_state  <= ST_FETCH;
                                rd_strobe <= 1'b1;
                            end
                            copper_pkg::OP_JMP: begin
                                pc        <= insn_q.jmp.target_pc;
                                ex_state  <= ST_FETCH;
                                rd_strobe <= 1'b1;
                            end
                            copper_pkg::OP_MOVER,
                            copper_pkg::OP_MOVEP: begin
                                // Hold in EXEC until the writer can take it
                                if (!wr_busy_i) begin
                                    ex_state  <= ST_FETCH;
                                    rd_strobe <= 1'b1;
                                end
                            end
                            default: begin
                                // MOVEF, MOVEC and reserved just fetch on
                                ex_state  <= ST_FETCH;
                                rd_strobe <= 1'b1;
                            end
                        endcase
                    end
                    default: begin
                        ex_state <= ST_INIT;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/copper_top.sv
// Copper top; program memory is external with one-cycle synchronous read, raster size set here
`default_nettype none
`timescale 1ns/1ps

module copper_top #(
    parameter int TOTAL_WIDTH  = 800,
    parameter int TOTAL_HEIGHT = 525
) (
    input  wire logic                   clk,
    input  wire logic                   copp_reset,
    // Control register write
    input  wire logic                   copp_reg_wr_i,
    input  wire copper_pkg::copp_ctrl_t copp_reg_data_i,
    // Beam position
    input  wire copper_pkg::hres_t      h_count_i,
    input  wire copper_pkg::vres_t      v_count_i,
    // Program memory read
    output      logic                   coppermem_rd_en_o,
    output      copper_pkg::copp_pc_t   coppermem_rd_addr_o,
    input  wire logic [31:0]            coppermem_rd_data_i,
    // XR write port
    output      logic                   xr_wr_en_o,
    output      copper_pkg::addr_t      xr_wr_addr_o,
    output      copper_pkg::word_t      xr_wr_data_o,
    input  wire logic                   xr_wr_ack_i
);

    copper_pkg::copp_ctrl_t   ctrl;
    logic                     frame_restart;
    copper_pkg::copper_insn_u insn;
    logic                     compare;
    logic                     cond_met;
    copper_pkg::xr_wr_req_t   wr_req;
    logic                     wr_busy;

    // Control register and end-of-frame detect
    copper_ctrl_reg #(
        .TOTAL_WIDTH  (TOTAL_WIDTH),
        .TOTAL_HEIGHT (TOTAL_HEIGHT)
    ) copper_ctrl_reg_i (
        .clk             (clk),
        .copp_reset      (copp_reset),
        .copp_reg_wr_i   (copp_reg_wr_i),
        .copp_reg_data_i (copp_reg_data_i),
        .h_count_i       (h_count_i),
        .v_count_i       (v_count_i),
        .ctrl_o          (ctrl),
        .frame_restart_o (frame_restart)
    );

    // Fetch and execute
    copper_sequencer copper_sequencer_i (
        .clk                 (clk),
        .copp_reset          (copp_reset),
        .ctrl_i              (ctrl),
        .frame_restart_i     (frame_restart),
        .coppermem_rd_data_i (coppermem_rd_data_i),
        .cond_met_i          (cond_met),
        .wr_busy_i           (wr_busy),
        .coppermem_rd_en_o   (coppermem_rd_en_o),
        .coppermem_rd_addr_o (coppermem_rd_addr_o),
        .insn_o              (insn),
        .compare_o           (compare),
        .wr_req_o            (wr_req)
    );

    // WAIT and SKIP position test
    copper_beam_compare copper_beam_compare_i (
        .clk        (clk),
        .copp_reset (copp_reset),
        .compare_i  (compare),
        .insn_i     (insn),
        .h_count_i  (h_count_i),
        .v_count_i  (v_count_i),
        .cond_met_o (cond_met)
    );

    // XR write handshake
    copper_xr_writer copper_xr_writer_i (
        .clk          (clk),
        .copp_reset   (copp_reset),
        .req_i        (wr_req),
        .xr_wr_ack_i  (xr_wr_ack_i),
        .wr_busy_o    (wr_busy),
        .xr_wr_en_o   (xr_wr_en_o),
        .xr_wr_addr_o (xr_wr_addr_o),
        .xr_wr_data_o (xr_wr_data_o)
    );

endmodule

`default_nettype wire

//--- logic/copper_xr_writer.sv
// Single-entry write holder; a new request is only legal while wr_busy_o is low
`default_nettype none
`timescale 1ns/1ps

module copper_xr_writer (
    input  wire logic                   clk,
    input  wire logic                   copp_reset,
    input  wire copper_pkg::xr_wr_req_t req_i,
    input  wire logic                   xr_wr_ack_i,
    output      logic                   wr_busy_o,
    output      logic                   xr_wr_en_o,
    output      copper_pkg::addr_t      xr_wr_addr_o,
    output      copper_pkg::word_t      xr_wr_data_o
);

    logic              wr_en_q;
    copper_pkg::addr_t wr_addr_q;
    copper_pkg::word_t wr_data_q;

    // Enable holds until the ack is seen
    // A new request in the ack cycle keeps it high for the next write
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            wr_en_q <= 1'b0;
        end else if (req_i.valid) begin
            wr_en_q <= 1'b1;
        end else if (xr_wr_ack_i) begin
            wr_en_q <= 1'b0;
        end
    end

    // Address and data stay put while the enable is up
    always_ff @(posedge clk) begin
        if (req_i.valid) begin
            wr_addr_q <= req_i.addr;
            wr_data_q <= req_i.data;
        end
    end

    // Pending and not being acked this cycle
    assign wr_busy_o = wr_en_q && !xr_wr_ack_i;

    // XR port
    assign xr_wr_en_o   = wr_en_q;
    assign xr_wr_addr_o = wr_addr_q;
    assign xr_wr_data_o = wr_data_q;

endmodule

`default_nettype wire

//--- sources.f
logic/copper_pkg.sv
logic/copper_ctrl_reg.sv
logic/copper_sequencer.sv
logic/copper_beam_compare.sv
logic/copper_xr_writer.sv
logic/copper_top.sv
verif/copper_checker.sv
verif/copper_tb.sv

//--- verif/copper_checker.sv
// Assumes one bind per target; ports that a target lacks are tied off by its bind
`timescale 1ns/1ps

module copper_checker (
    input wire logic              clk,
    input wire logic              copp_reset,
    input wire logic              wr_en_i,
    input wire logic              wr_ack_i,
    input wire logic              new_req_i,
    input wire copper_pkg::addr_t wr_addr_i,
    input wire copper_pkg::word_t wr_data_i,
    input wire logic              rd_en_i,
    input wire logic              copp_enable_i
);

    // Pending write keeps enable, address and data until the ack
    hold_until_ack: assert property (
        @(posedge clk) disable iff (copp_reset)
        wr_en_i && !wr_ack_i |=> wr_en_i && $stable(wr_addr_i) && $stable(wr_data_i)
    ) else $error("XR write changed or dropped before its acknowledge");

    // Acked write releases the port unless a new MOVE was queued in the same cycle
    drop_after_ack: assert property (
        @(posedge clk) disable iff (copp_reset)
        wr_en_i && wr_ack_i && !new_req_i |=> !wr_en_i
    ) else $error("XR write enable stayed high after its acknowledge");

    // Copper switched off
    no_read_when_off: assert property (
        @(posedge clk) disable iff (copp_reset)
        !copp_enable_i |-> !rd_en_i
    ) else $error("Program read while the copper is disabled");

    // Read strobe is a single-cycle pulse
    single_read_pulse: assert property (
        @(posedge clk) disable iff (copp_reset)
        rd_en_i |=> !rd_en_i
    ) else $error("Program read strobe held longer than one cycle");

endmodule

//--- verif/copper_tb.sv
// Raster 64x16; WAIT h targets in the program leave room before the line wraps
`timescale 1ns/1ps

module copper_tb;

    localparam int TOTAL_WIDTH  = 64;
    localparam int TOTAL_HEIGHT = 16;
    localparam int FRAME_CYCLES = TOTAL_WIDTH * TOTAL_HEIGHT;
    // Off for two frames before a partial one and three checked ones
    localparam int RUN_FRAMES   = 6;
    localparam int FRAMES_ON    = 4;
    localparam int RESTART_H    = TOTAL_WIDTH - 4;
    localparam int RESTART_V    = TOTAL_HEIGHT - 1;
    localparam copper_pkg::copp_pc_t INIT_PC = 10'h010;

    // One expected write and the WAIT that gates it
    typedef struct packed {
        copper_pkg::addr_t addr;
        copper_pkg::word_t data;
        copper_pkg::vres_t gate_v;
        copper_pkg::hres_t gate_h;
        logic              ign_v;
        logic              ign_h;
    } exp_wr_t;

    logic                   clk;
    logic                   copp_reset;
    logic                   copp_reg_wr_i;
    copper_pkg::copp_ctrl_t copp_reg_data_i;
    copper_pkg::hres_t      h_count_i;
    copper_pkg::vres_t      v_count_i;
    logic                   coppermem_rd_en_o;
    copper_pkg::copp_pc_t   coppermem_rd_addr_o;
    logic [31:0]            coppermem_rd_data_i;
    logic                   xr_wr_en_o;
    copper_pkg::addr_t      xr_wr_addr_o;
    copper_pkg::word_t      xr_wr_data_o;
    logic                   xr_wr_ack_i;

    logic [31:0] prog_mem [0:(1 << copper_pkg::COPP_W) - 1];
    exp_wr_t     exp_q [$];
    exp_wr_t     exp_wr;
    integer      ack_seed = 83;
    int          ack_delay = -1;
    logic        wr_done;
    bit          copp_enabled;
    bit          wr_started;
    int          start_v;
    int          start_h;
    int          frame_wr_cnt;
    int          frame_exp_cnt;
    int          frames_done;

    copper_top #(
        .TOTAL_WIDTH  (TOTAL_WIDTH),
        .TOTAL_HEIGHT (TOTAL_HEIGHT)
    ) copper_top_i (.*);

    bind copper_xr_writer copper_checker xr_checker_i (
        .clk (clk), .copp_reset (copp_reset),
        .wr_en_i (xr_wr_en_o), .wr_ack_i (xr_wr_ack_i), .new_req_i (req_i.valid),
        .wr_addr_i (xr_wr_addr_o), .wr_data_i (xr_wr_data_o),
        .rd_en_i (1'b0), .copp_enable_i (1'b1)
    );

    bind copper_sequencer copper_checker fetch_checker_i (
        .clk (clk), .copp_reset (copp_reset),
        .wr_en_i (1'b0), .wr_ack_i (1'b0), .new_req_i (1'b0),
        .wr_addr_i ('0), .wr_data_i ('0),
        .rd_en_i (coppermem_rd_en_o), .copp_enable_i (ctrl_i.enable)
    );

    always #4 clk = ~clk;

    // Beam counters advance once per clock
    always @(posedge clk) begin
        if (h_count_i == TOTAL_WIDTH - 1) begin
            h_count_i <= #1 '0;
            v_count_i <= #1 (v_count_i == TOTAL_HEIGHT - 1) ? '0 : v_count_i + 1'b1;
        end else begin
            h_count_i <= #1 h_count_i + 1'b1;
        end
    end

    // Program memory samples the address at the strobe edge
    always @(posedge clk) begin
        if (coppermem_rd_en_o) begin
            coppermem_rd_data_i <= #1 prog_mem[coppermem_rd_addr_o];
        end
    end

    // Ack after zero to three cycles
    // A zero delay lands in the first enable cycle
    always @(posedge clk) begin
        wr_done = xr_wr_en_o && xr_wr_ack_i;
        #1;
        xr_wr_ack_i = 1'b0;
        if (wr_done || copp_reset) begin
            ack_delay = -1;
        end
        if (xr_wr_en_o && !copp_reset) begin
            if (ack_delay < 0) begin
                ack_delay = $unsigned($random(ack_seed)) % 4;
            end
            if (ack_delay == 0) begin
                xr_wr_ack_i = 1'b1;
            end else begin
                ack_delay = ack_delay - 1;
            end
        end
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    function automatic logic [31:0] enc_pos(input copper_pkg::opcode_e op, input int v,
                                            input int h, input bit ign_v, input bit ign_h);
        return {op, 2'b00, copper_pkg::vres_t'(v), 1'b0, copper_pkg::hres_t'(h), 2'b00,
                ign_h, ign_v};
    endfunction

    function automatic logic [31:0] enc_move(input copper_pkg::opcode_e op, input int index,
                                             input int data);
        return {op, 4'h0, 9'(index), 16'(data)};
    endfunction

    function automatic logic [31:0] enc_jmp(input int target);
        return {copper_pkg::OP_JMP, 2'b00, copper_pkg::copp_pc_t'(target), 17'h0};
    endfunction

    // Position fields of a WAIT or SKIP word
    function automatic exp_wr_t gate_of(input copper_pkg::copper_insn_u insn);
        exp_wr_t g;
        g        = '0;
        g.gate_v = insn.pos.v_target;
        g.gate_h = insn.pos.h_target;
        g.ign_v  = insn.pos.ignore_v;
        g.ign_h  = insn.pos.ignore_h;
        return g;
    endfunction

    function automatic bit pos_reached(input exp_wr_t g, input int v, input int h);
        return (g.ign_v || v >= g.gate_v) && (g.ign_h || h >= g.gate_h);
    endfunction

    // Walk the program like the copper with the beam tracked as a lower bound
    function automatic void build_expected(input copper_pkg::copp_pc_t start_pc);
        copper_pkg::copper_insn_u insn;
        copper_pkg::copp_pc_t     pc;
        exp_wr_t                  gate;
        exp_wr_t                  wr;
        int                       cur_v;
        int                       cur_h;
        bit                       done;
        pc    = start_pc;
        cur_v = 0;
        cur_h = 0;
        done  = 1'b0;
        gate  = '0;
        gate.ign_v = 1'b1;
        gate.ign_h = 1'b1;
        exp_q.delete();
        for (int step = 0; step < 256 && !done; step++) begin
            insn = prog_mem[pc];
            pc   = pc + 1'b1;
            case (insn.pos.opcode)
                copper_pkg::OP_WAIT: begin
                    gate = gate_of(insn);
                    // Both ignored parks until the next frame
                    done = gate.ign_v && gate.ign_h;
                    if (!gate.ign_v && cur_v < gate.gate_v) begin
                        cur_v = gate.gate_v;
                        cur_h = 0;
                    end
                    if (!gate.ign_h && cur_h < gate.gate_h) begin
                        cur_h = gate.gate_h;
                    end
                end
                copper_pkg::OP_SKIP: begin
                    if (pos_reached(gate_of(insn), cur_v, cur_h)) begin
                        pc = pc + 1'b1;
                    end
                end
                copper_pkg::OP_JMP: begin
                    pc = insn.jmp.target_pc;
                end
                copper_pkg::OP_MOVER, copper_pkg::OP_MOVEP: begin
                    wr      = gate;
                    wr.data = insn.move.data;
                    if (insn.move.opcode == copper_pkg::OP_MOVEP) begin
                        // Upper seven bits of the color base over the palette index
                        wr.addr = (copper_pkg::XR_COLOR_MEM & 16'hFE00) |
                                  copper_pkg::addr_t'(insn.move.index);
                    end else begin
                        // Register number zero extended
                        wr.addr = copper_pkg::addr_t'(insn.move.index[7:0]);
                    end
                    exp_q.push_back(wr);
                    // Only the first write after a WAIT is gated by it
                    gate.ign_v = 1'b1;
                    gate.ign_h = 1'b1;
                end
                default: begin
                end
            endcase
        end
    endfunction

    task automatic load_program();
        // Reserved opcode everywhere with the address in the low bits
        for (int a = 0; a < (1 << copper_pkg::COPP_W); a++) begin
            prog_mem[a] = {3'b111, 19'h0, 10'(a)};
        end
        // Idle guard for the partial frame after enabling
        prog_mem[0]  = enc_pos(copper_pkg::OP_WAIT, 0, 0, 1, 1);
        prog_mem[16] = enc_move(copper_pkg::OP_MOVER, 'h012, 'hA001);
        prog_mem[17] = enc_move(copper_pkg::OP_MOVEP, 'h105, 'hB002);
        prog_mem[18] = enc_pos(copper_pkg::OP_WAIT, 2, 0, 0, 1);
        prog_mem[19] = enc_move(copper_pkg::OP_MOVER, 'h020, 'hC003);
        prog_mem[20] = enc_pos(copper_pkg::OP_WAIT, 0, 30, 1, 0);
        prog_mem[21] = enc_move(copper_pkg::OP_MOVEP, 'h0FF, 'hD004);
        prog_mem[22] = enc_pos(copper_pkg::OP_WAIT, 4, 20, 0, 0);
        prog_mem[23] = enc_move(copper_pkg::OP_MOVER, 'h031, 'hE005);
        // Taken skip followed by one that is not taken
        prog_mem[24] = enc_pos(copper_pkg::OP_SKIP, 0, 0, 0, 0);
        prog_mem[25] = enc_move(copper_pkg::OP_MOVER, 'h040, 'hDEAD);
        prog_mem[26] = enc_pos(copper_pkg::OP_SKIP, 12, 0, 0, 1);
        prog_mem[27] = enc_move(copper_pkg::OP_MOVER, 'h041, 'h1234);
        prog_mem[28] = enc_move(copper_pkg::OP_MOVEF, 'h042, 'h0BAD);
        prog_mem[29] = enc_move(copper_pkg::OP_MOVEC, 'h043, 'h0BAD);
        prog_mem[30] = enc_move(copper_pkg::OP_RSVD, 'h044, 'h0BAD);
        prog_mem[31] = enc_jmp(40);
        prog_mem[32] = enc_move(copper_pkg::OP_MOVER, 'h050, 'hBAD0);
        // Back-to-back moves overlap a pending write with the next fetch
        prog_mem[40] = enc_move(copper_pkg::OP_MOVEP, 'h001, 'h0F0F);
        prog_mem[41] = enc_move(copper_pkg::OP_MOVER, 'h07F, 'h5A5A);
        prog_mem[42] = enc_move(copper_pkg::OP_MOVER, 'h1FF, 'hFFFF);
        prog_mem[43] = enc_pos(copper_pkg::OP_WAIT, 0, 0, 1, 1);
        prog_mem[44] = enc_move(copper_pkg::OP_MOVER, 'h060, 'hBAD1);
    endtask

    // Compare each acked write and close each frame at the restart point
    always @(negedge clk) begin
        if (!copp_reset) begin
            assert (copp_enabled || !coppermem_rd_en_o)
                else stop_on_error("Program read while the copper is disabled");
            if (xr_wr_en_o && !wr_started) begin
                wr_started = 1'b1;
                start_v    = v_count_i;
                start_h    = h_count_i;
            end
            if (xr_wr_en_o && xr_wr_ack_i) begin
                wr_started = 1'b0;
                assert (frame_wr_cnt < frame_exp_cnt)
                    else stop_on_error("XR write seen beyond the expected list of the frame");
                exp_wr = exp_q[frame_wr_cnt];
                assert (xr_wr_addr_o == exp_wr.addr)
                    else stop_on_error($sformatf("** Error: xr_wr_addr_o = 0x%h, expected 0x%h",
                                                 xr_wr_addr_o, exp_wr.addr));
                assert (xr_wr_data_o == exp_wr.data)
                    else stop_on_error($sformatf("** Error: xr_wr_data_o = 0x%h, expected 0x%h",
                                                 xr_wr_data_o, exp_wr.data));
                assert (pos_reached(exp_wr, start_v, start_h))
                    else stop_on_error($sformatf(
                        "Write to %h started at v %0d h %0d before its WAIT",
                        exp_wr.addr, start_v, start_h));
                frame_wr_cnt = frame_wr_cnt + 1;
            end
            if (h_count_i == RESTART_H && v_count_i == RESTART_V) begin
                assert (frame_wr_cnt == frame_exp_cnt)
                    else stop_on_error($sformatf("** Error: frame_wr_cnt = 0x%h, expected 0x%h",
                                                 frame_wr_cnt, frame_exp_cnt));
                frame_wr_cnt  = 0;
                frame_exp_cnt = copp_enabled ? exp_q.size() : 0;
                if (copp_enabled) begin
                    frames_done = frames_done + 1;
                end
            end
        end
    end

    // Watchdog sized from the frame count
    initial begin
        #((RUN_FRAMES + 1) * FRAME_CYCLES * 8);
        stop_on_error("Watchdog expired before the checked frames completed");
    end

    initial begin
        clk                 = 1'b0;
        copp_reset          = 1'b1;
        copp_reg_wr_i       = 1'b0;
        copp_reg_data_i     = '0;
        h_count_i           = '0;
        v_count_i           = '0;
        coppermem_rd_data_i = '0;
        xr_wr_ack_i         = 1'b0;
        load_program();
        build_expected(INIT_PC);
        repeat (8) @(posedge clk);
        #1 copp_reset = 1'b0;
        // Copper off for two frames
        repeat (2 * FRAME_CYCLES) @(posedge clk);
        #1;
        copp_reg_data_i.enable  = 1'b1;
        copp_reg_data_i.init_pc = INIT_PC;
        copp_reg_wr_i           = 1'b1;
        copp_enabled            = 1'b1;
        @(posedge clk);
        #1 copp_reg_wr_i = 1'b0;
        wait (frames_done == FRAMES_ON);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
